//--- verilog/mem_pkg.sv
/* Bus widths and the data-side address map. Peripheral offsets are relative to PERIPH_BASE
   and each register is one full word; byte enables are not honored in the peripheral block. */

package mem_pkg;

    // one word of address and data, byte-granular enables
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W   = DATA_W / 8;

    // data addresses at or above this go to the pseudo-peripherals
    localparam logic [ADDR_W-1:0] PERIPH_BASE = 32'h2000_0000;

    // write: low byte goes to stdout
    localparam logic [ADDR_W-1:0] PRINT_OFS = 32'h0000_0000;

    // write: PASS_CODE marks a passed test, anything else a failed one
    localparam logic [ADDR_W-1:0] STATUS_OFS = 32'h0000_0004;

    // write: exit value, raises exit_valid
    localparam logic [ADDR_W-1:0] EXIT_OFS = 32'h0000_0008;

    // write: timer compare, also clears a pending timer irq
    localparam logic [ADDR_W-1:0] TCMP_OFS = 32'h0000_000C;

    // read only: free-running timer count
    localparam logic [ADDR_W-1:0] TCNT_OFS = 32'h0000_0010;

    localparam logic [DATA_W-1:0] PASS_CODE = 32'd123456789;

endpackage

//--- verilog/mem_bus_if.sv
/* One req/gnt/rvalid link. gnt is combinational, rvalid follows the grant by one cycle,
   and the master must take rvalid when it comes. */

`timescale 1ns/1ps

interface mem_bus_if;
    import mem_pkg::*;

    logic              req;
    logic              gnt;
    logic              rvalid;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;

    // request side holds addr/we/be/wdata until it sees gnt
    modport master (
        output req, we, be, addr, wdata,
        input  gnt, rvalid, rdata
    );

    modport slave (
        input  req, we, be, addr, wdata,
        output gnt, rvalid, rdata
    );

endinterface

//--- verilog/mem_arbiter.sv
/* Round-robin share of one RAM port between instruction fetch and data. Relies on the RAM
   granting every request, so the last winner is also the owner of the response in flight. */

`timescale 1ns/1ps

module mem_arbiter (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    input  logic                        instr_req_i,
    input  logic [mem_pkg::ADDR_W-1:0]  instr_addr_i,
    output logic                        instr_gnt_o,
    output logic                        instr_rvalid_o,
    output logic [mem_pkg::DATA_W-1:0]  instr_rdata_o,

    mem_bus_if.slave                    data_bus,
    mem_bus_if.master                   ram_bus
);

    localparam logic SEL_INSTR = 1'b0;
    localparam logic SEL_DATA  = 1'b1;

    logic last_win_q;
    logic pick_data;

    // on contention the master that did not win last time goes first
    always_comb begin
        if (instr_req_i && data_bus.req) begin
            pick_data = (last_win_q == SEL_INSTR);
        end else begin
            pick_data = data_bus.req;
        end
    end

    // instruction port is read only, full word
    assign ram_bus.req   = instr_req_i | data_bus.req;
    assign ram_bus.we    = pick_data & data_bus.we;
    assign ram_bus.be    = pick_data ? data_bus.be : '1;
    assign ram_bus.addr  = pick_data ? data_bus.addr : instr_addr_i;
    assign ram_bus.wdata = data_bus.wdata;

    assign instr_gnt_o   = ram_bus.gnt & instr_req_i & ~pick_data;
    assign data_bus.gnt  = ram_bus.gnt & pick_data;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            last_win_q <= SEL_INSTR;
        end else if (ram_bus.gnt) begin
            last_win_q <= pick_data ? SEL_DATA : SEL_INSTR;
        end
    end

    // response goes back only to the master that owns it
    assign instr_rvalid_o  = ram_bus.rvalid & (last_win_q == SEL_INSTR);
    assign data_bus.rvalid = ram_bus.rvalid & (last_win_q == SEL_DATA);
    assign instr_rdata_o   = ram_bus.rdata;
    assign data_bus.rdata  = ram_bus.rdata;

    // a master that loses arbitration is served in the next cycle
    a_instr_no_starve: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (instr_req_i && !instr_gnt_o) |=> (instr_gnt_o || !instr_req_i)
    ) else $error("instruction port lost arbitration twice in a row");

    a_data_no_starve: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (data_bus.req && !data_bus.gnt) |=> (data_bus.gnt || !data_bus.req)
    ) else $error("data port lost arbitration twice in a row");

endmodule

//--- verilog/sram_bank.sv
/* Single-ported word RAM, no reset on contents. Address bits above RAM_ADDR_WIDTH must be
   zero and bits [1:0] are ignored; every request is granted, rvalid one cycle later. */

`timescale 1ns/1ps

module sram_bank #(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  logic      clk_i,
    input  logic      rst_n_i,
    mem_bus_if.slave  bus
);
    import mem_pkg::*;

    localparam int unsigned BYTE_W = DATA_W / BE_W;
    localparam int unsigned DEPTH  = 2 ** (RAM_ADDR_WIDTH - 2);

    logic [DATA_W-1:0]         mem [DEPTH];
    logic [RAM_ADDR_WIDTH-3:0] word_idx;
    logic                      rvalid_q;
    logic [DATA_W-1:0]         rdata_q;

    assign word_idx   = bus.addr[RAM_ADDR_WIDTH-1:2];
    assign bus.gnt    = bus.req;
    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= bus.req;
        end
    end

    // byte lane writes, registered read data
    always_ff @(posedge clk_i) begin
        if (bus.req && bus.we) begin
            for (int b = 0; b < BE_W; b++) begin
                if (bus.be[b]) begin
                    mem[word_idx][b*BYTE_W +: BYTE_W] <= bus.wdata[b*BYTE_W +: BYTE_W];
                end
            end
        end
        if (bus.req && !bus.we) begin
            rdata_q <= mem[word_idx];
        end
    end

    // upstream trimming must keep every access inside the array
    a_addr_in_range: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        bus.gnt |-> ((bus.addr >> RAM_ADDR_WIDTH) == '0)
    ) else $error("RAM access beyond array: addr=%h", bus.addr);

endmodule

//--- verilog/data_router.sv
/* Steers the data port to the RAM or to the peripherals by PERIPH_BASE. RAM addresses are
   cut to RAM_ADDR_WIDTH bits; peripherals see the offset from PERIPH_BASE. */

`timescale 1ns/1ps

module data_router #(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    input  logic                        data_req_i,
    input  logic                        data_we_i,
    input  logic [mem_pkg::BE_W-1:0]    data_be_i,
    input  logic [mem_pkg::ADDR_W-1:0]  data_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]  data_wdata_i,
    output logic                        data_gnt_o,
    output logic                        data_rvalid_o,
    output logic [mem_pkg::DATA_W-1:0]  data_rdata_o,

    mem_bus_if.master                   ram_bus,
    mem_bus_if.master                   periph_bus
);
    import mem_pkg::*;

    logic is_periph;
    // side of the access in flight, 1 means peripheral
    logic side_q;

    assign is_periph = (data_addr_i >= PERIPH_BASE);

    assign ram_bus.req   = data_req_i & ~is_periph;
    assign ram_bus.we    = data_we_i;
    assign ram_bus.be    = data_be_i;
    assign ram_bus.addr  = ADDR_W'(data_addr_i[RAM_ADDR_WIDTH-1:0]);
    assign ram_bus.wdata = data_wdata_i;

    assign periph_bus.req   = data_req_i & is_periph;
    assign periph_bus.we    = data_we_i;
    assign periph_bus.be    = data_be_i;
    assign periph_bus.addr  = data_addr_i - PERIPH_BASE;
    assign periph_bus.wdata = data_wdata_i;

    assign data_gnt_o = is_periph ? periph_bus.gnt : ram_bus.gnt;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            side_q <= 1'b0;
        end else if (data_req_i && data_gnt_o) begin
            side_q <= is_periph;
        end
    end

    assign data_rvalid_o = side_q ? periph_bus.rvalid : ram_bus.rvalid;
    assign data_rdata_o  = side_q ? periph_bus.rdata : ram_bus.rdata;

    // a stray response on the other side would be silently dropped by the mux above
    a_one_source: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(ram_bus.rvalid && periph_bus.rvalid)
    ) else $error("RAM and peripheral responses in the same cycle");

endmodule

//--- verilog/sim_periph.sv
/* Pseudo-peripherals for a test harness: stdout, status, exit and a timer. Registers take
   full words regardless of byte enables; only TCNT reads back a nonzero value. */

`timescale 1ns/1ps

module sim_periph (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    mem_bus_if.slave                    bus,

    output logic                        print_valid_o,
    output logic [7:0]                  print_char_o,
    output logic                        tests_passed_o,
    output logic                        tests_failed_o,
    output logic                        exit_valid_o,
    output logic [mem_pkg::DATA_W-1:0]  exit_value_o,
    output logic                        irq_timer_o
);
    import mem_pkg::*;

    logic              wr;
    logic              rd;
    logic              rvalid_q;
    logic [DATA_W-1:0] rdata_q;
    logic              print_valid_q;
    logic [7:0]        print_char_q;
    logic              passed_q;
    logic              failed_q;
    logic              exit_valid_q;
    logic [DATA_W-1:0] exit_value_q;
    logic [DATA_W-1:0] tcmp_q;
    logic [DATA_W-1:0] tcnt_q;
    logic              irq_q;

    // always ready
    assign bus.gnt = bus.req;
    assign wr      = bus.req & bus.we;
    assign rd      = bus.req & ~bus.we;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_q      <= 1'b0;
            print_valid_q <= 1'b0;
            passed_q      <= 1'b0;
            failed_q      <= 1'b0;
            exit_valid_q  <= 1'b0;
            tcmp_q        <= '0;
            tcnt_q        <= '0;
            irq_q         <= 1'b0;
        end else begin
            rvalid_q      <= bus.req;
            print_valid_q <= wr && (bus.addr == PRINT_OFS);
            tcnt_q        <= tcnt_q + 1'b1;
            if (wr && bus.addr == STATUS_OFS) begin
                if (bus.wdata == PASS_CODE) begin
                    passed_q <= 1'b1;
                end else begin
                    failed_q <= 1'b1;
                end
            end
            if (wr && bus.addr == EXIT_OFS) begin
                exit_valid_q <= 1'b1;
            end
            // a compare write rearms the timer irq
            if (wr && bus.addr == TCMP_OFS) begin
                tcmp_q <= bus.wdata;
                irq_q  <= 1'b0;
            end else if (tcmp_q != '0 && tcnt_q == tcmp_q) begin
                irq_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr && bus.addr == PRINT_OFS) begin
            print_char_q <= bus.wdata[7:0];
        end
        if (wr && bus.addr == EXIT_OFS) begin
            exit_value_q <= bus.wdata;
        end
        rdata_q <= (rd && bus.addr == TCNT_OFS) ? tcnt_q : '0;
    end

    assign bus.rvalid     = rvalid_q;
    assign bus.rdata      = rdata_q;
    assign print_valid_o  = print_valid_q;
    assign print_char_o   = print_char_q;
    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;
    assign exit_valid_o   = exit_valid_q;
    assign exit_value_o   = exit_value_q;
    assign irq_timer_o    = irq_q;

    // software must report a single verdict per run
    a_one_verdict: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(tests_passed_o && tests_failed_o)
    ) else $error("test reported both passed and failed");

endmodule

//--- verilog/mm_ram_top.sv
/* Memory side of a core harness: shared RAM plus pseudo-peripherals. Instruction port is
   read only; RAM_ADDR_WIDTH sets the RAM size in bytes as a power of two. */

`timescale 1ns/1ps

module mm_ram_top #(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,

    // instruction fetch
    input  logic                        instr_req_i,
    input  logic [mem_pkg::ADDR_W-1:0]  instr_addr_i,
    output logic                        instr_gnt_o,
    output logic                        instr_rvalid_o,
    output logic [mem_pkg::DATA_W-1:0]  instr_rdata_o,

    // load/store
    input  logic                        data_req_i,
    input  logic                        data_we_i,
    input  logic [mem_pkg::BE_W-1:0]    data_be_i,
    input  logic [mem_pkg::ADDR_W-1:0]  data_addr_i,
    input  logic [mem_pkg::DATA_W-1:0]  data_wdata_i,
    output logic                        data_gnt_o,
    output logic                        data_rvalid_o,
    output logic [mem_pkg::DATA_W-1:0]  data_rdata_o,

    output logic                        print_valid_o,
    output logic [7:0]                  print_char_o,
    output logic                        tests_passed_o,
    output logic                        tests_failed_o,
    output logic                        exit_valid_o,
    output logic [mem_pkg::DATA_W-1:0]  exit_value_o,
    output logic                        irq_timer_o
);

    mem_bus_if data_ram_bus ();
    mem_bus_if periph_bus ();
    mem_bus_if ram_bus ();

    data_router #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) router_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .data_req_i    (data_req_i),
        .data_we_i     (data_we_i),
        .data_be_i     (data_be_i),
        .data_addr_i   (data_addr_i),
        .data_wdata_i  (data_wdata_i),
        .data_gnt_o    (data_gnt_o),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o),
        .ram_bus       (data_ram_bus),
        .periph_bus    (periph_bus)
    );

    mem_arbiter arbiter_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_bus       (data_ram_bus),
        .ram_bus        (ram_bus)
    );

    sram_bank #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) ram_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bus     (ram_bus)
    );

    sim_periph periph_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .bus            (periph_bus),
        .print_valid_o  (print_valid_o),
        .print_char_o   (print_char_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o),
        .irq_timer_o    (irq_timer_o)
    );

endmodule

//--- dv/tb_clk_gen.sv
/* Clock and power-on reset for the testbench. Reset is synchronous to the DUT and is
   released on a falling edge, after RESET_CYCLES rising edges. */

`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

//--- dv/tb_top.sv
/* Plays the core on both ports against a RAM and peripheral model. Traffic stays in a small
   RAM window that is preloaded first, because RAM contents have no reset. */

`timescale 1ns/1ps

module tb_top;
    import mem_pkg::*;

    localparam int          PERIOD_NS    = 20;
    localparam int          RESET_CYCLES = 16;
    localparam int          N_OPS        = 200;
    localparam int          WIN_WORDS    = 16;
    localparam logic [31:0] WIN_BASE     = 32'h0000_0100;
    localparam int          IRQ_DELAY    = 40;
    localparam int          QTR          = PERIOD_NS / 4;
    // gap, up to two cycles to grant, response and a random idle
    localparam int          CYC_PER_OP   = 8;
    localparam int          TOTAL_OPS    = 2 * N_OPS + 2 * WIN_WORDS + 16;
    localparam int          LIMIT_CYCLES = 2 * RESET_CYCLES + TOTAL_OPS * CYC_PER_OP
                                           + 2 * IRQ_DELAY;

    logic        clk;
    logic        gen_rst_n;
    logic        phase_rst_n;
    logic        rst_n;
    logic        instr_req;
    logic [31:0] instr_addr;
    logic        instr_gnt;
    logic        instr_rvalid;
    logic [31:0] instr_rdata;
    logic        data_req;
    logic        data_we;
    logic [3:0]  data_be;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic        data_gnt;
    logic        data_rvalid;
    logic [31:0] data_rdata;
    logic        print_valid;
    logic [7:0]  print_char;
    logic        tests_passed;
    logic        tests_failed;
    logic        exit_valid;
    logic [31:0] exit_value;
    logic        irq_timer;

    // word-indexed RAM model
    logic [31:0] ram_model [int unsigned];
    int          checks = 0;
    int          errors = 0;

    assign rst_n = gen_rst_n & phase_rst_n;

    tb_clk_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) clk_gen_i (
        .clk_o   (clk),
        .rst_n_o (gen_rst_n)
    );

    mm_ram_top #(.RAM_ADDR_WIDTH(16)) DUT (
        .clk_i (clk), .rst_n_i (rst_n),
        .instr_req_i (instr_req), .instr_addr_i (instr_addr), .instr_gnt_o (instr_gnt),
        .instr_rvalid_o (instr_rvalid), .instr_rdata_o (instr_rdata),
        .data_req_i (data_req), .data_we_i (data_we), .data_be_i (data_be),
        .data_addr_i (data_addr), .data_wdata_i (data_wdata), .data_gnt_o (data_gnt),
        .data_rvalid_o (data_rvalid), .data_rdata_o (data_rdata),
        .print_valid_o (print_valid), .print_char_o (print_char),
        .tests_passed_o (tests_passed), .tests_failed_o (tests_failed),
        .exit_valid_o (exit_valid), .exit_value_o (exit_value), .irq_timer_o (irq_timer)
    );

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("t=%0t %s", $time, what);
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                                input logic [3:0] be);
        logic [31:0] w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return w;
    endfunction

    // one data-port access, returns at the falling edge of its response cycle
    task automatic data_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int          waited;
        logic [31:0] exp;
        waited = 0;
        exp    = '0;
        @(negedge clk);
        data_req   = 1'b1;
        data_we    = we;
        data_be    = be;
        data_addr  = addr;
        data_wdata = wdata;
        #(QTR);
        check_value("data_rvalid", 1'b0, data_rvalid);
        while (!data_gnt) begin
            @(negedge clk);
            #(QTR);
            waited++;
            check_value("data_rvalid", 1'b0, data_rvalid);
        end
        check_true(waited <= 1, "data request was not granted within two cycles");
        // granted at the coming rising edge
        if (addr < PERIPH_BASE) begin
            if (we) begin
                ram_model[addr[31:2]] = merge_bytes(ram_model[addr[31:2]], wdata, be);
            end else begin
                exp = ram_model[addr[31:2]];
            end
        end
        @(negedge clk);
        check_value("data_rvalid", 1'b1, data_rvalid);
        rdata = data_rdata;
        if (addr < PERIPH_BASE && !we) begin
            check_value("data_rdata", exp, rdata);
        end
        data_req = 1'b0;
    endtask

    task automatic instr_fetch(input logic [31:0] addr);
        int          waited;
        logic [31:0] exp;
        waited = 0;
        @(negedge clk);
        instr_req  = 1'b1;
        instr_addr = addr;
        #(QTR);
        check_value("instr_rvalid", 1'b0, instr_rvalid);
        while (!instr_gnt) begin
            @(negedge clk);
            #(QTR);
            waited++;
            check_value("instr_rvalid", 1'b0, instr_rvalid);
        end
        check_true(waited <= 1, "instruction request was not granted within two cycles");
        exp = ram_model[addr[31:2]];
        @(negedge clk);
        check_value("instr_rvalid", 1'b1, instr_rvalid);
        check_value("instr_rdata", exp, instr_rdata);
        instr_req = 1'b0;
    endtask

    task automatic data_traffic();
        logic [31:0] addr;
        logic [31:0] rd;
        for (int i = 0; i < N_OPS; i++) begin
            addr = WIN_BASE + 32'(4 * $urandom_range(WIN_WORDS - 1, 0));
            if ($urandom_range(1, 0) == 1) begin
                data_access(1'b1, 4'($urandom_range(15, 1)), addr, $urandom, rd);
            end else begin
                data_access(1'b0, 4'hF, addr, 32'h0, rd);
            end
            repeat ($urandom_range(2, 0)) @(negedge clk);
        end
    endtask

    task automatic fetch_traffic();
        for (int i = 0; i < N_OPS; i++) begin
            instr_fetch(WIN_BASE + 32'(4 * $urandom_range(WIN_WORDS - 1, 0)));
            repeat ($urandom_range(2, 0)) @(negedge clk);
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] val;
        logic [31:0] t0;
        logic [31:0] t1;
        logic [7:0]  ch;
        int          wait_cyc;
        void'($urandom(32'hb7d0));
        phase_rst_n = 1'b1;
        instr_req   = 1'b0;
        instr_addr  = '0;
        data_req    = 1'b0;
        data_we     = 1'b0;
        data_be     = '0;
        data_addr   = '0;
        data_wdata  = '0;
        @(posedge gen_rst_n);

        for (int w = 0; w < WIN_WORDS; w++) begin
            data_access(1'b1, 4'hF, WIN_BASE + 32'(4 * w), $urandom, rd);
        end
        fork
            data_traffic();
            fetch_traffic();
        join

        // stdout write must leave the RAM alone
        ch = 8'($urandom);
        data_access(1'b1, 4'hF, PERIPH_BASE + PRINT_OFS, {24'($urandom), ch}, rd);
        check_value("print_valid", 1'b1, print_valid);
        check_value("print_char", ch, print_char);
        @(negedge clk);
        check_value("print_valid", 1'b0, print_valid);
        for (int w = 0; w < WIN_WORDS; w++) begin
            data_access(1'b0, 4'hF, WIN_BASE + 32'(4 * w), 32'h0, rd);
        end

        val = $urandom;
        check_value("exit_valid", 1'b0, exit_valid);
        data_access(1'b1, 4'hF, PERIPH_BASE + EXIT_OFS, val, rd);
        check_value("exit_valid", 1'b1, exit_valid);
        check_value("exit_value", val, exit_value);
        data_access(1'b1, 4'hF, PERIPH_BASE + STATUS_OFS, PASS_CODE, rd);
        check_value("tests_passed", 1'b1, tests_passed);
        check_value("tests_failed", 1'b0, tests_failed);

        check_value("irq_timer", 1'b0, irq_timer);
        data_access(1'b0, 4'hF, PERIPH_BASE + TCNT_OFS, 32'h0, t0);
        data_access(1'b1, 4'hF, PERIPH_BASE + TCMP_OFS, t0 + IRQ_DELAY, rd);
        // t0 is the count three cycles back, so irq rises IRQ_DELAY - 2 cycles from here
        wait_cyc = 0;
        while (!irq_timer && wait_cyc < 2 * IRQ_DELAY) begin
            @(negedge clk);
            wait_cyc++;
        end
        check_true(irq_timer, "timer interrupt did not rise after the compare write");
        check_value("irq_timer rise cycle", IRQ_DELAY - 2, wait_cyc);
        data_access(1'b0, 4'hF, PERIPH_BASE + TCNT_OFS, 32'h0, t1);
        check_true(t1 > t0, $sformatf("timer count did not increase: %0d then %0d", t0, t1));
        check_value("irq_timer", 1'b1, irq_timer);
        data_access(1'b1, 4'hF, PERIPH_BASE + TCMP_OFS, 32'h0, rd);
        check_value("irq_timer", 1'b0, irq_timer);

        // second phase starts from a fresh reset
        @(negedge clk);
        phase_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        check_value("tests_passed", 1'b0, tests_passed);
        check_value("exit_valid", 1'b0, exit_valid);
        check_value("irq_timer", 1'b0, irq_timer);
        phase_rst_n = 1'b1;
        val = $urandom;
        if (val == PASS_CODE) begin
            val = ~val;
        end
        data_access(1'b1, 4'hF, PERIPH_BASE + STATUS_OFS, val, rd);
        check_value("tests_failed", 1'b1, tests_failed);
        check_value("tests_passed", 1'b0, tests_passed);

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(LIMIT_CYCLES * PERIOD_NS);
        $display("timeout: run did not complete within %0d cycles", LIMIT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- tb.f
verilog/mem_pkg.sv
verilog/mem_bus_if.sv
verilog/mem_arbiter.sv
verilog/sram_bank.sv
verilog/data_router.sv
verilog/sim_periph.sv
verilog/mm_ram_top.sv
dv/tb_clk_gen.sv
dv/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, and judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_top -o tb_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 || echo "simulator exited with an error status"

grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST OK" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"
